// ==== hdl/force_pkg.sv ====
/* Localparams, particle id union, force vector, stream beat and force record types
   shared by the force accumulation stage */
`default_nettype none

package force_pkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////

	// Signed fixed point force component
	localparam int FORCE_W = 32;
	// Cell coordinate and slot fields of a particle id
	localparam int CELL_W = 2;
	localparam int SLOT_W = 4;
	localparam int PID_W = 3 * CELL_W + SLOT_W;
	localparam int CACHE_DEPTH = 1 << PID_W;
	// Saturating counter of finished records
	localparam int DONE_W = 16;

	// Clamp limits of one lane
	localparam logic signed [FORCE_W-1:0] FORCE_MAX = {1'b0, {(FORCE_W-1){1'b1}}};
	localparam logic signed [FORCE_W-1:0] FORCE_MIN = {1'b1, {(FORCE_W-1){1'b0}}};

	////////////////////////////////////////////////////////////
	// Host address map
	////////////////////////////////////////////////////////////

	localparam int AXIL_ADDR_W = 16;
	localparam int AXIL_DATA_W = 32;
	// Status and control word, above the force region
	localparam logic [AXIL_ADDR_W-1:0] STATUS_ADDR = 16'hC000;
	// Word select and particle id positions in a force address
	localparam int ADDR_WORD_LSB = 2;
	localparam int ADDR_PID_LSB = 4;
	// Words of one force entry
	localparam logic [1:0] WORD_FX = 2'd0;
	localparam logic [1:0] WORD_FY = 2'd1;
	localparam logic [1:0] WORD_FZ = 2'd2;
	localparam logic [1:0] WORD_STAT = 2'd3;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// Cell coordinates and slot, cell_x in the top bits
	typedef struct packed {
		logic [CELL_W-1:0] cell_x;
		logic [CELL_W-1:0] cell_y;
		logic [CELL_W-1:0] cell_z;
		logic [SLOT_W-1:0] slot;
	} pid_fields_t;

	// Same id word seen flat or split into fields
	typedef union packed {
		logic [PID_W-1:0] raw;
		pid_fields_t fields;
	} particle_id_u;

	typedef struct packed {
		logic signed [FORCE_W-1:0] fx;
		logic signed [FORCE_W-1:0] fy;
		logic signed [FORCE_W-1:0] fz;
	} force_vec_t;

	// One beat of the partial force stream
	typedef struct packed {
		logic valid;
		logic last;
		particle_id_u pid;
		force_vec_t fvec;
	} partial_beat_t;

	// Finished force of one particle, ovf set if any axis clamped
	typedef struct packed {
		particle_id_u pid;
		force_vec_t fvec;
		logic ovf;
	} force_rec_t;

endpackage

`default_nettype wire

// ==== hdl/force_acc_lane.sv ====
/* One axis saturating fixed point accumulator with sticky overflow */
`timescale 1ns/1ps
`default_nettype none

module force_acc_lane
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic add_en,
	input  logic signed [force_pkg::FORCE_W-1:0] addend,
	output logic signed [force_pkg::FORCE_W-1:0] sum,
	output logic ovf
);
	import force_pkg::*;

	// Starting point of this add, zero on a new group
	logic signed [FORCE_W-1:0] base;
	// Extra top bit exposes the carry past the sign
	logic signed [FORCE_W:0] wide;
	logic clamp_hi;
	logic clamp_lo;

	assign base = start ? '0 : sum;
	assign wide = {base[FORCE_W-1], base} + {addend[FORCE_W-1], addend};

	// Top two bits disagree only when the add left the 32-bit range
	assign clamp_hi = (wide[FORCE_W -: 2] == 2'b01);
	assign clamp_lo = (wide[FORCE_W -: 2] == 2'b10);

	// Running sum
	always_ff @(posedge clk)
	begin
		if (add_en)
		begin
			if (clamp_hi)
				sum <= FORCE_MAX;
			else if (clamp_lo)
				sum <= FORCE_MIN;
			else
				sum <= wide[FORCE_W-1:0];
		end
	end

	// Sticky flag, restarts with the sum
	always_ff @(posedge clk)
	begin
		if (rst)
			ovf <= 1'b0;
		else if (add_en)
			ovf <= (start ? 1'b0 : ovf) | clamp_hi | clamp_lo;
	end

endmodule

`default_nettype wire

// ==== hdl/partial_force_acc.sv ====
/* Groups stream beats by particle id and emits one finished force record
   per group through three saturating lanes */
`timescale 1ns/1ps
`default_nettype none

module partial_force_acc
(
	input  logic clk,
	input  logic rst,
	input  force_pkg::partial_beat_t in_beat,
	output force_pkg::force_rec_t acc_rec,
	output logic acc_rec_valid
);
	import force_pkg::*;

	// Open group
	logic grp_open;
	particle_id_u cur_pid;

	// Lane results
	logic signed [FORCE_W-1:0] sum_x;
	logic signed [FORCE_W-1:0] sum_y;
	logic signed [FORCE_W-1:0] sum_z;
	logic ovf_x;
	logic ovf_y;
	logic ovf_z;

	// Beat classification
	logic same_grp;
	logic close_old;
	logic close_last;

	// Record candidates
	force_rec_t lane_rec;
	force_rec_t beat_rec;

	// Output stage and one deep pending slot
	logic rec_live;
	force_rec_t rec_hold;
	logic pend_valid;
	force_rec_t pend_rec;

	assign same_grp = grp_open && (in_beat.pid.raw == cur_pid.raw);
	// Valid beat of another id ends the open group
	assign close_old = in_beat.valid && grp_open && !same_grp;
	assign close_last = in_beat.valid && in_beat.last;

	// Group currently held in the lanes
	assign lane_rec.pid = cur_pid;
	assign lane_rec.fvec.fx = sum_x;
	assign lane_rec.fvec.fy = sum_y;
	assign lane_rec.fvec.fz = sum_z;
	assign lane_rec.ovf = ovf_x | ovf_y | ovf_z;

	// A group of one beat is the beat itself, no clamp possible
	assign beat_rec.pid = in_beat.pid;
	assign beat_rec.fvec = in_beat.fvec;
	assign beat_rec.ovf = 1'b0;

	// After a last beat the lanes hold the group until the next valid beat
	assign acc_rec = rec_live ? lane_rec : rec_hold;

	////////////////////////////////////////////////////////////
	// Group state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			grp_open <= 1'b0;
		else if (in_beat.valid)
			grp_open <= !in_beat.last;
	end

	always_ff @(posedge clk)
	begin
		if (in_beat.valid)
			cur_pid <= in_beat.pid;
	end

	////////////////////////////////////////////////////////////
	// Record output
	////////////////////////////////////////////////////////////

	// Id change plus last closes two groups at once, second one slips a cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc_rec_valid <= 1'b0;
			rec_live <= 1'b0;
			pend_valid <= 1'b0;
		end
		else
		begin
			rec_live <= 1'b0;
			if (pend_valid || close_old)
			begin
				acc_rec_valid <= 1'b1;
				pend_valid <= close_last;
			end
			else if (close_last)
			begin
				acc_rec_valid <= 1'b1;
				rec_live <= same_grp;
			end
			else
				acc_rec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pend_valid)
			rec_hold <= pend_rec;
		else if (close_old)
			rec_hold <= lane_rec;
		else if (close_last)
			rec_hold <= beat_rec;
		if (close_last)
			pend_rec <= beat_rec;
	end

	// Lanes restart with the new beat on an id change
	force_acc_lane lane_x (
		.clk(clk), .rst(rst), .start(!same_grp), .add_en(in_beat.valid),
		.addend(in_beat.fvec.fx), .sum(sum_x), .ovf(ovf_x)
	);

	force_acc_lane lane_y (
		.clk(clk), .rst(rst), .start(!same_grp), .add_en(in_beat.valid),
		.addend(in_beat.fvec.fy), .sum(sum_y), .ovf(ovf_y)
	);

	force_acc_lane lane_z (
		.clk(clk), .rst(rst), .start(!same_grp), .add_en(in_beat.valid),
		.addend(in_beat.fvec.fz), .sum(sum_z), .ovf(ovf_z)
	);

endmodule

`default_nettype wire

// ==== hdl/force_cache.sv ====
/* Force memory indexed by particle id, per entry valid bits,
   done counter and overflow summary */
`timescale 1ns/1ps
`default_nettype none

module force_cache
(
	input  logic clk,
	input  logic rst,
	input  force_pkg::force_rec_t acc_rec,
	input  logic acc_rec_valid,
	input  force_pkg::particle_id_u rd_pid,
	output force_pkg::force_rec_t rd_rec,
	output logic rd_hit,
	input  logic clear_stats,
	output logic [force_pkg::DONE_W-1:0] done_count,
	output logic ovf_seen
);
	import force_pkg::*;

	// One record per particle id
	force_rec_t mem [CACHE_DEPTH];
	// Entry written since reset
	logic [CACHE_DEPTH-1:0] entry_valid;

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////

	// Repeated id simply overwrites
	always_ff @(posedge clk)
	begin
		if (acc_rec_valid)
			mem[acc_rec.pid.raw] <= acc_rec;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			entry_valid <= '0;
		else if (acc_rec_valid)
			entry_valid[acc_rec.pid.raw] <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////

	// Registered read, result one cycle after rd_pid
	always_ff @(posedge clk)
	begin
		rd_rec <= mem[rd_pid.raw];
		rd_hit <= entry_valid[rd_pid.raw];
	end

	////////////////////////////////////////////////////////////
	// Statistics
	////////////////////////////////////////////////////////////

	// Host clear wins over a record in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst || clear_stats)
		begin
			done_count <= '0;
			ovf_seen <= 1'b0;
		end
		else if (acc_rec_valid)
		begin
			// Counter sticks at all ones
			if (done_count != '1)
				done_count <= done_count + 1'b1;
			if (acc_rec.ovf)
				ovf_seen <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/axil_force_reader.sv ====
/* AXI4-Lite slave for the host, force words, entry status,
   status word and the statistics clear */
`timescale 1ns/1ps
`default_nettype none

module axil_force_reader
(
	input  logic clk,
	input  logic rst,
	// Write address and data
	input  logic [force_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [force_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [force_pkg::AXIL_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	// Write response
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	// Read address
	input  logic [force_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	// Read data
	output logic [force_pkg::AXIL_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	// Cache side
	output force_pkg::particle_id_u rd_pid,
	input  force_pkg::force_rec_t rd_rec,
	input  logic rd_hit,
	input  logic [force_pkg::DONE_W-1:0] done_count,
	input  logic ovf_seen,
	output logic clear_stats
);
	import force_pkg::*;

	logic ar_go;
	logic wr_go;
	// First cycle of rvalid, cache data is live
	logic rd_first;
	logic rd_is_force;
	logic rd_is_status;
	logic [1:0] rd_word;
	logic [AXIL_DATA_W-1:0] rd_word_live;
	logic [AXIL_DATA_W-1:0] rdata_q;

	////////////////////////////////////////////////////////////
	// Read channel
	////////////////////////////////////////////////////////////

	assign arready = !rvalid;
	assign ar_go = arvalid && arready;
	assign rresp = RESP_OKAY;

	// Id straight from the address so the cache read lands with rvalid
	always_comb
	begin
		rd_pid.fields.slot = araddr[ADDR_PID_LSB +: SLOT_W];
		rd_pid.fields.cell_z = araddr[ADDR_PID_LSB + SLOT_W +: CELL_W];
		rd_pid.fields.cell_y = araddr[ADDR_PID_LSB + SLOT_W + CELL_W +: CELL_W];
		rd_pid.fields.cell_x = araddr[ADDR_PID_LSB + SLOT_W + 2 * CELL_W +: CELL_W];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rvalid <= 1'b0;
			rd_first <= 1'b0;
		end
		else if (ar_go)
		begin
			rvalid <= 1'b1;
			rd_first <= 1'b1;
		end
		else
		begin
			rd_first <= 1'b0;
			if (rready)
				rvalid <= 1'b0;
		end
	end

	// Remember what the request selected
	always_ff @(posedge clk)
	begin
		if (ar_go)
		begin
			rd_is_force <= (araddr < STATUS_ADDR);
			rd_is_status <= (araddr == STATUS_ADDR);
			rd_word <= araddr[ADDR_WORD_LSB +: 2];
		end
		// Freeze the word while the response waits for rready
		if (rd_first)
			rdata_q <= rd_word_live;
	end

	// Word formed from the returning cache read or the statistics
	always_comb
	begin
		rd_word_live = '0;
		if (rd_is_status)
		begin
			rd_word_live[DONE_W-1:0] = done_count;
			rd_word_live[DONE_W] = ovf_seen;
		end
		else if (rd_is_force)
		begin
			// Unwritten entries read as zero
			case (rd_word)
				WORD_FX: rd_word_live = rd_hit ? rd_rec.fvec.fx : '0;
				WORD_FY: rd_word_live = rd_hit ? rd_rec.fvec.fy : '0;
				WORD_FZ: rd_word_live = rd_hit ? rd_rec.fvec.fz : '0;
				WORD_STAT: rd_word_live = {{(AXIL_DATA_W-2){1'b0}}, rd_hit & rd_rec.ovf, rd_hit};
				default: rd_word_live = '0;
			endcase
		end
	end

	assign rdata = rd_first ? rd_word_live : rdata_q;

	////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////

	// Address and data taken together, blocked while a response waits
	assign wr_go = awvalid && wvalid && !bvalid;
	assign awready = wr_go;
	assign wready = wr_go;
	assign bresp = RESP_OKAY;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bvalid <= 1'b0;
			clear_stats <= 1'b0;
		end
		else
		begin
			// One cycle pulse on a control write with bit 0 set
			clear_stats <= wr_go && (awaddr == STATUS_ADDR) && wstrb[0] && wdata[0];
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/force_accum_top.sv ====
/* Force accumulation stage top, stream in, accumulator, cache and host port */
`timescale 1ns/1ps
`default_nettype none

module force_accum_top
(
	input  logic clk,
	input  logic rst,
	// Partial force stream
	input  force_pkg::partial_beat_t in_beat,
	// Host port
	input  logic [force_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
	input  logic s_axil_awvalid,
	output logic s_axil_awready,
	input  logic [force_pkg::AXIL_DATA_W-1:0] s_axil_wdata,
	input  logic [force_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb,
	input  logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input  logic s_axil_bready,
	input  logic [force_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
	input  logic s_axil_arvalid,
	output logic s_axil_arready,
	output logic [force_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input  logic s_axil_rready
);
	import force_pkg::*;

	// Finished records
	force_rec_t acc_rec;
	logic acc_rec_valid;

	// Host lookups
	particle_id_u rd_pid;
	force_rec_t rd_rec;
	logic rd_hit;

	// Statistics
	logic [DONE_W-1:0] done_count;
	logic ovf_seen;
	logic clear_stats;

	partial_force_acc u_acc (
		.clk(clk), .rst(rst), .in_beat(in_beat),
		.acc_rec(acc_rec), .acc_rec_valid(acc_rec_valid)
	);

	force_cache u_cache (
		.clk(clk), .rst(rst), .acc_rec(acc_rec), .acc_rec_valid(acc_rec_valid),
		.rd_pid(rd_pid), .rd_rec(rd_rec), .rd_hit(rd_hit),
		.clear_stats(clear_stats), .done_count(done_count), .ovf_seen(ovf_seen)
	);

	axil_force_reader u_host (
		.clk(clk), .rst(rst),
		.awaddr(s_axil_awaddr), .awvalid(s_axil_awvalid), .awready(s_axil_awready),
		.wdata(s_axil_wdata), .wstrb(s_axil_wstrb), .wvalid(s_axil_wvalid),
		.wready(s_axil_wready), .bresp(s_axil_bresp), .bvalid(s_axil_bvalid),
		.bready(s_axil_bready), .araddr(s_axil_araddr), .arvalid(s_axil_arvalid),
		.arready(s_axil_arready), .rdata(s_axil_rdata), .rresp(s_axil_rresp),
		.rvalid(s_axil_rvalid), .rready(s_axil_rready),
		.rd_pid(rd_pid), .rd_rec(rd_rec), .rd_hit(rd_hit),
		.done_count(done_count), .ovf_seen(ovf_seen), .clear_stats(clear_stats)
	);

endmodule

`default_nettype wire

// ==== test/force_accum_assert.sv ====
/* Bound checks on AXI4-Lite responses and the record valid after reset */
`timescale 1ns/1ps
`default_nettype none

module force_accum_assert
(
	input  logic clk,
	input  logic rst,
	input  logic rvalid,
	input  logic rready,
	input  logic [force_pkg::AXIL_DATA_W-1:0] rdata,
	input  logic bvalid,
	input  logic bready,
	input  logic acc_rec_valid
);

	// Count of failed assertions
	int fail_count = 0;

	// Read response holds until taken
	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
	else
	begin
		$error("rvalid dropped before rready");
		fail_count++;
	end

	// Read data frozen while waiting
	r_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> $stable(rdata))
	else
	begin
		$error("rdata changed while rvalid waited");
		fail_count++;
	end

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
	else
	begin
		$error("bvalid dropped before bready");
		fail_count++;
	end

	// No record straight out of reset
	rec_reset: assert property (@(posedge clk)
		rst |=> !acc_rec_valid)
	else
	begin
		$error("acc_rec_valid high right after reset");
		fail_count++;
	end

endmodule

bind force_accum_top force_accum_assert u_assert (
	.clk(clk), .rst(rst),
	.rvalid(s_axil_rvalid), .rready(s_axil_rready), .rdata(s_axil_rdata),
	.bvalid(s_axil_bvalid), .bready(s_axil_bready),
	.acc_rec_valid(acc_rec_valid)
);

`default_nettype wire

// ==== test/force_accum_tb.sv ====
/* Testbench for the force accumulation stage, stream stimulus,
   reference group sums and AXI4-Lite readback checks */
`timescale 1ns/1ps
`default_nettype none

module force_accum_tb;
	import force_pkg::*;

	localparam int TIMEOUT = 50;
	localparam logic [31:0] SEED = 32'h3dcde717;
	localparam longint LIM_HI = 64'sd2147483647;
	localparam longint LIM_LO = -64'sd2147483648;

	logic clk;
	logic rst;
	partial_beat_t in_beat;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXIL_DATA_W-1:0] wdata;
	logic [AXIL_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXIL_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// Expected cache contents with status as {ovf, valid}
	logic [FORCE_W-1:0] exp_fx [CACHE_DEPTH];
	logic [FORCE_W-1:0] exp_fy [CACHE_DEPTH];
	logic [FORCE_W-1:0] exp_fz [CACHE_DEPTH];
	logic [1:0] exp_stat [CACHE_DEPTH];

	// Grouping model of the sent stream
	logic model_open;
	logic [PID_W-1:0] model_pid;
	int qx[$];
	int qy[$];
	int qz[$];
	logic [DONE_W-1:0] groups_sent;
	logic any_ovf;

	force_accum_top uut (
		.clk(clk), .rst(rst), .in_beat(in_beat),
		.s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
		.s_axil_wdata(wdata), .s_axil_wstrb(wstrb), .s_axil_wvalid(wvalid),
		.s_axil_wready(wready), .s_axil_bresp(bresp), .s_axil_bvalid(bvalid),
		.s_axil_bready(bready), .s_axil_araddr(araddr), .s_axil_arvalid(arvalid),
		.s_axil_arready(arready), .s_axil_rdata(rdata), .s_axil_rresp(rresp),
		.s_axil_rvalid(rvalid), .s_axil_rready(rready)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// In-order add clamped to signed 32 bits at every step with ovf in the top bit
	function automatic logic [FORCE_W:0] saturated_sum(input int vals[$]);
		longint acc;
		logic ovf;
		acc = 0;
		ovf = 1'b0;
		foreach (vals[i])
		begin
			acc = acc + longint'(vals[i]);
			if (acc > LIM_HI)
			begin
				acc = LIM_HI;
				ovf = 1'b1;
			end
			else if (acc < LIM_LO)
			begin
				acc = LIM_LO;
				ovf = 1'b1;
			end
		end
		return {ovf, acc[FORCE_W-1:0]};
	endfunction

	// Moderate random force that cannot overflow in short groups
	function automatic int random_force();
		int r;
		r = $urandom;
		return r >>> 8;
	endfunction

	// Word address of one entry
	function automatic logic [AXIL_ADDR_W-1:0] entry_addr(input logic [PID_W-1:0] pid,
		input logic [1:0] word);
		return {2'b00, pid, word, 2'b00};
	endfunction

	task automatic close_group();
		logic [FORCE_W:0] rx;
		logic [FORCE_W:0] ry;
		logic [FORCE_W:0] rz;
		rx = saturated_sum(qx);
		ry = saturated_sum(qy);
		rz = saturated_sum(qz);
		exp_fx[model_pid] = rx[FORCE_W-1:0];
		exp_fy[model_pid] = ry[FORCE_W-1:0];
		exp_fz[model_pid] = rz[FORCE_W-1:0];
		exp_stat[model_pid] = {rx[FORCE_W] | ry[FORCE_W] | rz[FORCE_W], 1'b1};
		any_ovf = any_ovf | exp_stat[model_pid][1];
		groups_sent = groups_sent + 1'b1;
		qx.delete();
		qy.delete();
		qz.delete();
		model_open = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	// Called on a falling edge and returns on the next one
	task automatic send_beat(input logic valid, input logic last,
		input logic [PID_W-1:0] pid, input int fx, input int fy, input int fz);
		in_beat.valid = valid;
		in_beat.last = last;
		in_beat.pid.raw = pid;
		in_beat.fvec.fx = fx;
		in_beat.fvec.fy = fy;
		in_beat.fvec.fz = fz;
		if (valid)
		begin
			// Id change closes the open group first
			if (model_open && pid != model_pid)
				close_group();
			model_open = 1'b1;
			model_pid = pid;
			qx.push_back(fx);
			qy.push_back(fy);
			qz.push_back(fz);
			if (last)
				close_group();
		end
		@(negedge clk);
	endtask

	task automatic idle_stream(input int cycles);
		in_beat.valid = 1'b0;
		in_beat.last = 1'b0;
		repeat (cycles) @(negedge clk);
	endtask

	// Read with rready held low for hold cycles after rvalid
	task automatic read_word(input logic [AXIL_ADDR_W-1:0] addr, input int hold,
		output logic [AXIL_DATA_W-1:0] data);
		int cnt;
		logic [AXIL_DATA_W-1:0] first;
		araddr = addr;
		arvalid = 1'b1;
		cnt = 0;
		while (!arready)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				fail_run("Timeout waiting for arready");
			@(negedge clk);
		end
		// Handshake on the rising edge in between
		@(negedge clk);
		arvalid = 1'b0;
		// Address bus moves on once the request is taken
		araddr = '0;
		cnt = 0;
		while (!rvalid)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				fail_run("Timeout waiting for rvalid");
			@(negedge clk);
		end
		first = rdata;
		repeat (hold)
		begin
			@(negedge clk);
			compare_word("rvalid held", {31'b0, rvalid}, 32'd1);
			compare_word("rdata held", rdata, first);
		end
		compare_word("rresp", {30'b0, rresp}, 32'd0);
		data = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_word(input logic [AXIL_ADDR_W-1:0] addr,
		input logic [AXIL_DATA_W-1:0] data);
		int cnt;
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = '1;
		wvalid = 1'b1;
		cnt = 0;
		// Ready depends on the valids just driven
		#1;
		while (!(awready && wready))
		begin
			cnt++;
			if (cnt > TIMEOUT)
				fail_run("Timeout waiting for awready");
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		cnt = 0;
		while (!bvalid)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				fail_run("Timeout waiting for bvalid");
			@(negedge clk);
		end
		compare_word("bresp", {30'b0, bresp}, 32'd0);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic check_entry(input logic [PID_W-1:0] pid);
		logic [AXIL_DATA_W-1:0] data;
		read_word(entry_addr(pid, WORD_FX), 0, data);
		compare_word($sformatf("fx[%03h]", pid), data, exp_fx[pid]);
		read_word(entry_addr(pid, WORD_FY), 0, data);
		compare_word($sformatf("fy[%03h]", pid), data, exp_fy[pid]);
		read_word(entry_addr(pid, WORD_FZ), 0, data);
		compare_word($sformatf("fz[%03h]", pid), data, exp_fz[pid]);
		read_word(entry_addr(pid, WORD_STAT), 0, data);
		compare_word($sformatf("status[%03h]", pid), data, {30'b0, exp_stat[pid]});
	endtask

	task automatic check_unwritten(input logic [PID_W-1:0] pid, input int hold);
		logic [AXIL_DATA_W-1:0] data;
		read_word(entry_addr(pid, WORD_STAT), hold, data);
		compare_word($sformatf("status[%03h]", pid), data, 32'd0);
	endtask

	task automatic check_status();
		logic [AXIL_DATA_W-1:0] data;
		read_word(STATUS_ADDR, 0, data);
		compare_word("status word", data, {15'b0, any_ovf, groups_sent});
	endtask

	initial
	begin
		int seed_ret;
		logic [AXIL_DATA_W-1:0] data;
		seed_ret = $urandom(SEED);
		clk = 1'b0;
		rst = 1'b1;
		in_beat = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		model_open = 1'b0;
		model_pid = '0;
		groups_sent = '0;
		any_ovf = 1'b0;
		foreach (exp_stat[i])
		begin
			exp_fx[i] = '0;
			exp_fy[i] = '0;
			exp_fz[i] = '0;
			exp_stat[i] = 2'b00;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// One group closed by last
		for (int i = 0; i < 5; i++)
			send_beat(1'b1, i == 4, 10'h015, random_force(), random_force(), random_force());
		idle_stream(4);
		check_entry(10'h015);

		// Back to back groups split by id change with the last one a single beat
		for (int i = 0; i < 3; i++)
			send_beat(1'b1, 1'b0, 10'h0a3, random_force(), random_force(), random_force());
		for (int i = 0; i < 4; i++)
			send_beat(1'b1, 1'b0, 10'h1c7, random_force(), random_force(), random_force());
		send_beat(1'b1, 1'b1, 10'h2f0, random_force(), random_force(), random_force());
		idle_stream(4);
		check_entry(10'h0a3);
		check_entry(10'h1c7);
		check_entry(10'h2f0);

		// Invalid beats of other ids inside a group with some flagged last
		for (int i = 0; i < 6; i++)
		begin
			send_beat(1'b1, i == 5, 10'h333, random_force(), random_force(), random_force());
			if (i < 5)
				send_beat(1'b0, 1'b1, (i % 2 == 1) ? 10'h044 : 10'h055,
					random_force(), random_force(), random_force());
		end
		idle_stream(4);
		check_entry(10'h333);
		check_unwritten(10'h044, 0);
		check_unwritten(10'h055, 0);

		// Large same sign forces clamp on x and y
		for (int i = 0; i < 4; i++)
			send_beat(1'b1, i == 3, 10'h3e9, 32'sh7000_0000, 32'sh9000_0000, random_force());
		idle_stream(4);
		check_entry(10'h3e9);

		// Done counter and an ignored write before the clear
		check_status();
		write_word(entry_addr(10'h015, WORD_FX), 32'h1);
		check_status();
		write_word(STATUS_ADDR, 32'h1);
		groups_sent = '0;
		any_ovf = 1'b0;
		check_status();

		// Held R channel on an unwritten entry and on a force word
		check_unwritten(10'h2aa, 5);
		read_word(entry_addr(10'h015, WORD_FY), 3, data);
		compare_word("fy[015] held", data, exp_fy[10'h015]);

		if (uut.u_assert.fail_count != 0)
			fail_run("A bound protocol assertion failed during the run");
		else
		begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/force_pkg.sv
hdl/force_acc_lane.sv
hdl/partial_force_acc.sv
hdl/force_cache.sv
hdl/axil_force_reader.sv
hdl/force_accum_top.sv
test/force_accum_assert.sv
test/force_accum_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the force accumulation testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
	-f all.f --top-module force_accum_tb -o force_accum_sim \
	&& ./obj_dir/force_accum_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
